// ==== build.f ====
+incdir+.
zap_mem_pkg.sv
zap_main_mem.sv
zap_store_align.sv
zap_load_align.sv
zap_fetch_unit.sv
zap_ls_ctrl.sv
zap_mem_top.sv
zap_mem_properties.sv
zap_mem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the zap_mem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
        --top-module zap_mem_tb -Mdir obj_dir -o zap_mem_sim
if [ $? -ne 0 ]; then
        echo "Verilator build failed."
        exit 1
fi

./obj_dir/zap_mem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
        exit 1
fi
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status."
        exit 1
fi
exit 0

// ==== zap_fetch_unit.sv ====
`timescale 1ns/1ps
`include "zap_mem_config.svh"

module zap_fetch_unit
(
        input  logic                            i_clk,
        input  logic                            i_rst_n,

        input  logic                            i_fetch_en,
        input  logic                            i_redirect,
        input  logic [`ZAP_ADDR_W-1:0]          i_redirect_pc,

        input  logic [31:0]                     i_idata,
        output logic [`ZAP_ADDR_W-1:0]          o_iaddress,

        output zap_mem_pkg::fetch_out_t         o_instr,
        output logic                            o_instr_valid
);

logic [`ZAP_ADDR_W-1:0] pc;

assign o_iaddress = pc;

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                pc            <= `ZAP_RESET_PC;
                o_instr_valid <= 1'b0;
        end
        else if (i_redirect)
        begin
                pc            <= i_redirect_pc;
                o_instr_valid <= 1'b0;  // Drop old stream.
        end
        else if (i_fetch_en)
        begin
                pc            <= pc + `ZAP_ADDR_W'(4);
                o_instr_valid <= 1'b1;
        end
        else
        begin
                o_instr_valid <= 1'b0;
        end
end

// Payload, captured with its own address.
always_ff @(posedge i_clk)
begin
        if (i_fetch_en && !i_redirect)
        begin
                o_instr.instr <= i_idata;
                o_instr.addr  <= pc;
        end
end

endmodule

// ==== zap_load_align.sv ====
`timescale 1ns/1ps

module zap_load_align
(
        input  zap_mem_pkg::ls_op_t     i_op,
        input  logic [1:0]              i_addr_lo,
        input  logic [31:0]             i_word,
        output logic [31:0]             o_data
);

import zap_mem_pkg::*;

logic [7:0]  byte_sel;
logic [15:0] half_sel;

// Lane pick.
always_comb
begin
        case (i_addr_lo)
        2'd0:    byte_sel = i_word[7:0];
        2'd1:    byte_sel = i_word[15:8];
        2'd2:    byte_sel = i_word[23:16];
        default: byte_sel = i_word[31:24];
        endcase

        half_sel = i_addr_lo[1] ? i_word[31:16] : i_word[15:0];
end

// Extension.
always_comb
begin
        case (i_op)
        LB:      o_data = {{24{byte_sel[7]}}, byte_sel};
        LBU:     o_data = {24'd0, byte_sel};
        LH:      o_data = {{16{half_sel[15]}}, half_sel};
        LHU:     o_data = {16'd0, half_sel};
        default: o_data = i_word;       // LW; stores don't care.
        endcase
end

endmodule

// ==== zap_ls_ctrl.sv ====
`timescale 1ns/1ps

module zap_ls_ctrl
(
        input  logic                    i_clk,
        input  logic                    i_rst_n,

        input  logic                    i_ls_valid,
        input  zap_mem_pkg::ls_req_t    i_ls_req,

        input  logic                    i_misaligned,   // From store align.
        input  zap_mem_pkg::mem_wr_t    i_wr,
        input  logic [31:0]             i_ld_data,      // Extended load value.

        output zap_mem_pkg::ls_req_t    o_stage_req,
        output zap_mem_pkg::mem_wr_t    o_wr,

        output logic [31:0]             o_ld_data,
        output logic                    o_ld_valid,
        output logic                    o_ls_err
);

import zap_mem_pkg::*;

logic           stage_vld;
ls_req_t        stage_req;
logic           is_load;
logic           s2_ld_vld;
logic           s2_err;
logic [31:0]    s2_data;

assign o_stage_req = stage_req;
assign is_load     = stage_req.op inside {LB, LBU, LH, LHU, LW};

// Only a live, aligned store reaches the array.
always_comb
begin
        o_wr       = i_wr;
        o_wr.wr_en = i_wr.wr_en & stage_vld & ~i_misaligned;
end

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                stage_vld  <= 1'b0;
                s2_ld_vld  <= 1'b0;
                s2_err     <= 1'b0;
                o_ld_valid <= 1'b0;
                o_ls_err   <= 1'b0;
        end
        else
        begin
                stage_vld  <= i_ls_valid;
                s2_ld_vld  <= stage_vld & is_load & ~i_misaligned;
                s2_err     <= stage_vld & i_misaligned;
                o_ld_valid <= s2_ld_vld;
                o_ls_err   <= s2_err;
        end
end

always_ff @(posedge i_clk)
begin
        if (i_ls_valid)
                stage_req <= i_ls_req;
        s2_data   <= i_ld_data;
        o_ld_data <= s2_data;
end

endmodule

// ==== zap_main_mem.sv ====
`timescale 1ns/1ps
`include "zap_mem_config.svh"

module zap_main_mem
#(
        parameter int SIZE_IN_BYTES = `ZAP_MEM_BYTES
)
(
        input  logic                            i_clk,

        input  logic [`ZAP_ADDR_W-1:0]          i_iaddress,     // Fetch side.
        input  zap_mem_pkg::mem_wr_t            i_wr,           // Data write.
        input  logic [`ZAP_ADDR_W-1:0]          i_daddress,     // Data read.

        output logic [31:0]                     o_ddata,
        output logic [31:0]                     o_idata
);

localparam int DEPTH = SIZE_IN_BYTES / 4;
localparam int IDX_W = $clog2(DEPTH);

logic [IDX_W-1:0] widx;
logic [IDX_W-1:0] didx;
logic [IDX_W-1:0] iidx;

assign widx = i_wr.word_addr[IDX_W-1:0];
assign didx = i_daddress[IDX_W+1:2];
assign iidx = i_iaddress[IDX_W+1:2];

// One byte-wide array per lane.
for (genvar l = 0; l < 4; l++)
begin : g_lane
        logic [7:0] lane_mem [DEPTH];

        initial
        begin
                for (int i = 0; i < DEPTH; i++)
                        lane_mem[i] = 8'd0;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_wr.wr_en && i_wr.ben[l])
                        lane_mem[widx] <= i_wr.data[8*l +: 8];
        end

        // Both reads are asynchronous.
        assign o_ddata[8*l +: 8] = lane_mem[didx];
        assign o_idata[8*l +: 8] = lane_mem[iidx];
end

endmodule

// ==== zap_mem_config.svh ====
`ifndef ZAP_MEM_CONFIG_SVH
`define ZAP_MEM_CONFIG_SVH

// Unified memory size in bytes.
`define ZAP_MEM_BYTES 4096

// Byte address width.
`define ZAP_ADDR_W 32

// First fetch address out of reset.
`define ZAP_RESET_PC 32'h0000_0000

`endif

// ==== zap_mem_pkg.sv ====
`include "zap_mem_config.svh"

package zap_mem_pkg;

typedef enum logic [2:0]
{
        LB  = 3'd0,
        LBU = 3'd1,
        LH  = 3'd2,
        LHU = 3'd3,
        LW  = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
} ls_op_t;

typedef struct packed
{
        ls_op_t                         op;
        logic [`ZAP_ADDR_W-1:0]         addr;   // Byte address.
        logic [31:0]                    data;   // Unshifted store data.
} ls_req_t;

typedef struct packed
{
        logic                           wr_en;
        logic [3:0]                     ben;
        logic [`ZAP_ADDR_W-1:0]         word_addr;      // Byte address >> 2.
        logic [31:0]                    data;           // Already on its lanes.
} mem_wr_t;

typedef struct packed
{
        logic [31:0]                    instr;
        logic [`ZAP_ADDR_W-1:0]         addr;
} fetch_out_t;

endpackage

// ==== zap_mem_properties.sv ====
`timescale 1ns/1ps

module zap_mem_properties
(
        input logic     i_clk,
        input logic     i_rst_n,
        input logic     i_fetch_en,
        input logic     i_redirect,
        input logic     o_ld_valid,
        input logic     o_ls_err,
        input logic     o_instr_valid
);

// A load slot holds data or an error, never both.
a_ld_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_ld_valid && o_ls_err))
        else $error("o_ld_valid and o_ls_err high together");

a_reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |=> !(o_ld_valid || o_ls_err || o_instr_valid))
        else $error("Strobe high during reset");

// Valid instruction only after an enabled fetch without redirect.
a_instr_src: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_instr_valid |-> $past(i_fetch_en && !i_redirect))
        else $error("o_instr_valid without a fetch");

endmodule

bind zap_mem_top zap_mem_properties zap_mem_properties_i
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_en     (i_fetch_en),
        .i_redirect     (i_redirect),
        .o_ld_valid     (o_ld_valid),
        .o_ls_err       (o_ls_err),
        .o_instr_valid  (o_instr_valid)
);

// ==== zap_mem_tb.sv ====
`timescale 1ns/1ps
`include "zap_mem_config.svh"

module zap_mem_tb;

import zap_mem_pkg::*;

localparam int CLK_PERIOD   = 4;
localparam int RESET_CYCLES = 16;
localparam int MEM_AW       = $clog2(`ZAP_MEM_BYTES);
localparam int N_WORD       = 40;
localparam int N_SUB        = 60;
localparam int N_MIS        = 20;
localparam int N_FETCH      = 20;
localparam int N_REDIR      = 6;
localparam int REDIR_RUN    = 8;
localparam int TEST_CYCLES  = 24 + 4 * N_WORD + N_SUB + 2 * N_MIS + N_FETCH
                              + (REDIR_RUN + 1) * N_REDIR + 8;

typedef struct packed
{
        logic           ld;
        logic           err;
        logic [31:0]    data;
} exp_t;

logic                   i_clk;
logic                   i_rst_n;
logic                   i_ls_valid;
ls_req_t                i_ls_req;
logic                   i_fetch_en;
logic                   i_redirect;
logic [`ZAP_ADDR_W-1:0] i_redirect_pc;
logic [31:0]            o_ld_data;
logic                   o_ld_valid;
logic                   o_ls_err;
fetch_out_t             o_instr;
logic                   o_instr_valid;

logic [7:0]             model_mem [`ZAP_MEM_BYTES];
exp_t                   exp_q [$];      // Load slot, three steps deep.
logic [31:0]            rng_state;
logic [`ZAP_ADDR_W-1:0] pc_m;
logic                   f_valid;
logic [31:0]            f_instr;
logic [`ZAP_ADDR_W-1:0] f_addr;

zap_mem_top zap_mem_top_i
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_ls_valid     (i_ls_valid),
        .i_ls_req       (i_ls_req),
        .i_fetch_en     (i_fetch_en),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .o_ld_data      (o_ld_data),
        .o_ld_valid     (o_ld_valid),
        .o_ls_err       (o_ls_err),
        .o_instr        (o_instr),
        .o_instr_valid  (o_instr_valid)
);

always #(CLK_PERIOD / 2) i_clk = ~i_clk;

function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
endfunction

function automatic logic [`ZAP_ADDR_W-1:0] rand_addr();
        return lcg_next() % `ZAP_MEM_BYTES;
endfunction

function automatic logic [31:0] read_word(input logic [`ZAP_ADDR_W-1:0] addr);
        logic [MEM_AW-1:0] b;
        b = {addr[MEM_AW-1:2], 2'b00};
        return {model_mem[b + MEM_AW'(3)], model_mem[b + MEM_AW'(2)],
                model_mem[b + MEM_AW'(1)], model_mem[b]};
endfunction

// Little endian; the byte at the lowest address sits in bits 7:0.
function automatic exp_t predict_ls(input logic valid, input ls_req_t r);
        exp_t                   e;
        logic [MEM_AW-1:0]      a;
        logic                   mis;
        e   = '0;
        a   = r.addr[MEM_AW-1:0];
        mis = ((r.op inside {LH, LHU, SH}) && r.addr[0]) ||
              ((r.op inside {LW, SW}) && (r.addr[1:0] != 2'b00));
        if (valid && mis)
                e.err = 1'b1;
        else if (valid)
        begin
                e.ld = !(r.op inside {SB, SH, SW});
                case (r.op)
                SB: model_mem[a] = r.data[7:0];
                SH:
                begin
                        model_mem[a]              = r.data[7:0];
                        model_mem[a + MEM_AW'(1)] = r.data[15:8];
                end
                SW:
                begin
                        for (int k = 0; k < 4; k++)
                                model_mem[a + MEM_AW'(k)] = r.data[8*k +: 8];
                end
                LB:  e.data = {{24{model_mem[a][7]}}, model_mem[a]};
                LBU: e.data = {24'd0, model_mem[a]};
                LH:  e.data = {{16{model_mem[a + MEM_AW'(1)][7]}},
                               model_mem[a + MEM_AW'(1)], model_mem[a]};
                LHU: e.data = {16'd0, model_mem[a + MEM_AW'(1)], model_mem[a]};
                default: e.data = read_word(r.addr);
                endcase
        end
        return e;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                $display("ERR time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
                $display("ERRORS FOUND");
                $fatal(1, "Mismatch on %s.", name);
        end
endtask

// One clock: check what the last edge produced, then drive the next inputs.
task automatic step(input logic valid, input ls_req_t req, input logic fen,
                    input logic redir, input logic [`ZAP_ADDR_W-1:0] rpc);
        exp_t e;
        @(posedge i_clk);
        #1;
        e = exp_q.pop_front();
        check("o_ld_valid", 32'(o_ld_valid), 32'(e.ld));
        check("o_ls_err", 32'(o_ls_err), 32'(e.err));
        if (e.ld)
                check("o_ld_data", o_ld_data, e.data);
        check("o_instr_valid", 32'(o_instr_valid), 32'(f_valid));
        if (f_valid)
        begin
                check("o_instr.instr", o_instr.instr, f_instr);
                check("o_instr.addr", o_instr.addr, f_addr);
        end
        i_ls_valid    = valid;
        i_ls_req      = req;
        i_fetch_en    = fen;
        i_redirect    = redir;
        i_redirect_pc = rpc;
        exp_q.push_back(predict_ls(valid, req));
        f_valid = fen && !redir;        // Redirect wins.
        if (redir)
                pc_m = rpc;
        else if (fen)
        begin
                f_instr = read_word(pc_m);
                f_addr  = pc_m;
                pc_m    = pc_m + 32'd4;
        end
endtask

task automatic issue(input ls_op_t op, input logic [`ZAP_ADDR_W-1:0] addr,
                     input logic [31:0] data);
        ls_req_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        step(1'b1, r, 1'b0, 1'b0, '0);
endtask

task automatic idle(input int n);
        repeat (n) step(1'b0, '0, 1'b0, 1'b0, '0);
endtask

initial
begin
        logic [`ZAP_ADDR_W-1:0] a;
        logic [31:0]            n;
        ls_op_t                 op;
        i_clk         = 1'b0;
        i_rst_n       = 1'b0;
        i_ls_valid    = 1'b0;
        i_ls_req      = '0;
        i_fetch_en    = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        rng_state     = 32'hd1fe720e;
        pc_m          = `ZAP_RESET_PC;
        f_valid       = 1'b0;
        f_instr       = '0;
        f_addr        = '0;
        for (int i = 0; i < `ZAP_MEM_BYTES; i++)
                model_mem[MEM_AW'(i)] = 8'd0;
        repeat (3) exp_q.push_back('0);
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        idle(4);                        // Quiet after reset.
        for (int k = 0; k < 16; k++)
                issue(SW, `ZAP_RESET_PC + 32'(4 * k), lcg_next());
        for (int k = 0; k < N_WORD; k++)
        begin
                a = rand_addr() & ~32'd3;
                issue(SW, a, lcg_next());
                issue(LW, a, '0);       // Same word, next cycle.
                issue(LW, rand_addr() & ~32'd3, '0);
                if (lcg_next() > 32'h8000_0000)
                        idle(1);
        end
        for (int k = 0; k < N_SUB; k++)
        begin
                n  = lcg_next() % 6;
                op = (n < 4) ? ls_op_t'(n[2:0]) : ls_op_t'(n[2:0] + 3'd1);
                a  = 32'h100 + (lcg_next() % 64);
                if (op inside {LH, LHU, SH})
                        a[0] = 1'b0;
                issue(op, a, lcg_next());
        end
        for (int k = 0; k < N_MIS; k++)
        begin
                n = lcg_next() % 5;
                case (n)
                0:       op = LH;
                1:       op = LHU;
                2:       op = SH;
                3:       op = LW;
                default: op = SW;
                endcase
                a = 32'h100 + (lcg_next() % 64);
                if (op inside {LH, LHU, SH})
                        a[0] = 1'b1;
                else
                        a[1:0] = 2'(lcg_next() % 3) + 2'd1;
                issue(op, a, lcg_next());
                issue(LW, a & ~32'd3, '0);
        end
        idle(4);
        repeat (N_FETCH) step(1'b0, '0, 1'b1, 1'b0, '0);
        for (int k = 0; k < N_REDIR; k++)
        begin
                step(1'b0, '0, 1'(k % 2), 1'b1, rand_addr() & ~32'd3);
                repeat (REDIR_RUN) step(1'b0, '0, 1'b1, 1'b0, '0);
        end
        idle(4);                        // Fetch off, nothing valid.
        $display("NO ERRORS");
        $finish;
end

initial
begin
        #(CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES + 200));
        $display("Timeout: the run did not finish within its cycle budget.");
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired.");
end

endmodule

// ==== zap_mem_top.sv ====
`timescale 1ns/1ps
`include "zap_mem_config.svh"

module zap_mem_top
(
        input  logic                            i_clk,
        input  logic                            i_rst_n,

        input  logic                            i_ls_valid,
        input  zap_mem_pkg::ls_req_t            i_ls_req,

        input  logic                            i_fetch_en,
        input  logic                            i_redirect,
        input  logic [`ZAP_ADDR_W-1:0]          i_redirect_pc,

        output logic [31:0]                     o_ld_data,
        output logic                            o_ld_valid,
        output logic                            o_ls_err,

        output zap_mem_pkg::fetch_out_t         o_instr,
        output logic                            o_instr_valid
);

import zap_mem_pkg::*;

ls_req_t                stage_req;
mem_wr_t                st_wr;
mem_wr_t                mem_wr;
logic                   misaligned;
logic [31:0]            ddata;
logic [31:0]            idata;
logic [31:0]            ld_ext;
logic [`ZAP_ADDR_W-1:0] iaddress;

zap_ls_ctrl u_ls_ctrl
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_ls_valid     (i_ls_valid),
        .i_ls_req       (i_ls_req),
        .i_misaligned   (misaligned),
        .i_wr           (st_wr),
        .i_ld_data      (ld_ext),
        .o_stage_req    (stage_req),
        .o_wr           (mem_wr),
        .o_ld_data      (o_ld_data),
        .o_ld_valid     (o_ld_valid),
        .o_ls_err       (o_ls_err)
);

zap_store_align u_store_align
(
        .i_req          (stage_req),
        .o_wr           (st_wr),
        .o_misaligned   (misaligned)
);

zap_load_align u_load_align
(
        .i_op           (stage_req.op),
        .i_addr_lo      (stage_req.addr[1:0]),
        .i_word         (ddata),
        .o_data         (ld_ext)
);

zap_fetch_unit u_fetch_unit
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_en     (i_fetch_en),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_idata        (idata),
        .o_iaddress     (iaddress),
        .o_instr        (o_instr),
        .o_instr_valid  (o_instr_valid)
);

zap_main_mem u_main_mem
(
        .i_clk          (i_clk),
        .i_iaddress     (iaddress),
        .i_wr           (mem_wr),
        .i_daddress     (stage_req.addr),
        .o_ddata        (ddata),
        .o_idata        (idata)
);

endmodule

// ==== zap_store_align.sv ====
`timescale 1ns/1ps

module zap_store_align
(
        input  zap_mem_pkg::ls_req_t    i_req,
        output zap_mem_pkg::mem_wr_t    o_wr,
        output logic                    o_misaligned
);

import zap_mem_pkg::*;

logic [1:0] lo;

assign lo = i_req.addr[1:0];

always_comb
begin
        o_wr           = '0;
        o_wr.word_addr = i_req.addr >> 2;
        o_misaligned   = 1'b0;

        case (i_req.op)
        SB:
        begin
                o_wr.wr_en = 1'b1;
                o_wr.ben   = 4'b0001 << lo;
                o_wr.data  = i_req.data << {lo, 3'b000};
        end
        SH:
        begin
                o_wr.wr_en   = 1'b1;
                o_wr.ben     = 4'b0011 << {lo[1], 1'b0};
                o_wr.data    = i_req.data << {lo[1], 4'b0000};
                o_misaligned = lo[0];
        end
        SW:
        begin
                o_wr.wr_en   = 1'b1;
                o_wr.ben     = 4'b1111;
                o_wr.data    = i_req.data;
                o_misaligned = |lo;
        end
        LH, LHU: o_misaligned = lo[0];  // Loads never write.
        LW:      o_misaligned = |lo;
        default: o_misaligned = 1'b0;   // Byte loads.
        endcase
end

endmodule
